/* common/pcie_pkg.sv */
/*
 * PCIe side definitions: tag and length types, completion
 * header codes and field offsets, receive beat and read request
 */

package pcie_pkg;

    localparam int NUM_TAGS = 32;

    typedef logic [63:0] host_addr_t;   // byte address
    typedef logic [4:0]  tag_t;
    typedef logic [9:0]  dw_len_t;      // tlp length field
    typedef logic [2:0]  max_rd_code_t; // devctl max read request size

    localparam logic [6:0] FMT_TYPE_CPLD = 7'b100_1010;
    localparam logic [2:0] CPL_STATUS_SC = 3'b000;

    //////////////////////////////////////////////////
    // completion header field offsets
    //////////////////////////////////////////////////
    localparam int FMT_TYPE_LSB   = 56; // beat 0
    localparam int CPL_LEN_LSB    = 32; // beat 0
    localparam int CPL_STATUS_LSB = 13; // beat 0
    localparam int CPL_TAG_LSB    = 40; // beat 1

    // one 64-bit beat of the receive stream
    typedef struct packed {
        logic [63:0] data;
        logic        sof;
        logic        eof;
        logic        valid;
    } rx_beat_t;

    // memory read request, length in qws
    typedef struct packed {
        host_addr_t  addr;
        logic [7:0]  qw;
    } rd_req_t;

endpackage

/* common/ibuf_pkg.sv */
/*
 * Receive ring types, outstanding read limit,
 * descriptor, issue, completion start and ring write structs
 */

package ibuf_pkg;

    localparam int RING_AW         = 9;
    localparam int MAX_OUTSTANDING = 4;
    localparam int OS_PTR_W        = $clog2(MAX_OUTSTANDING);

    typedef logic [RING_AW:0]   ring_ptr_t;  // msb is the wrap bit
    typedef logic [RING_AW-1:0] ring_addr_t;
    typedef logic [19:0]        qw_cnt_t;    // buffer length
    typedef logic [7:0]         rq_qw_t;     // one request, at most 128

    // ring size in qws, sized for the space check
    localparam logic [RING_AW+1:0] RING_QWS = {2'b01, {RING_AW{1'b0}}};

    typedef struct packed {
        pcie_pkg::tag_t tag;
        rq_qw_t         qw;
        ring_ptr_t      base;    // first ring slot of the request
    } issue_evt_t;

    typedef struct packed {
        pcie_pkg::tag_t    tag;
        pcie_pkg::dw_len_t len;
    } cpl_start_t;

    typedef struct packed {
        logic        en;
        ring_addr_t  addr;
        logic [63:0] data;
    } ring_wr_t;

    typedef struct packed {
        pcie_pkg::host_addr_t addr;
        qw_cnt_t              len;
    } lbuf_desc_t;

endpackage

/* ibuf_mgmt/rd_req_gen.sv */
/*
 * Read request generator: splits a host buffer into reads
 * bounded by max read size, outstanding count and ring space
 */

module rd_req_gen (
    input  logic                   clk,
    input  logic                   rst,
    input  ibuf_pkg::lbuf_desc_t   lbuf,
    input  logic                   lbuf_valid,
    output logic                   lbuf_ready,
    input  pcie_pkg::max_rd_code_t cfg_max_rd,
    output pcie_pkg::rd_req_t      rd,
    output logic                   rd_valid,
    input  logic                   rd_ack,
    input  pcie_pkg::tag_t         rd_tag,
    input  ibuf_pkg::ring_ptr_t    committed_cons,
    input  logic                   retire_valid,
    output ibuf_pkg::issue_evt_t   issue,
    output logic                   issue_valid,
    output logic                   lbuf_done
);

    typedef enum logic [2:0] {
        S_IDLE, S_SIZE, S_WAIT, S_REQ, S_NEXT, S_DONE
    } state_t;

    state_t                        state;
    pcie_pkg::host_addr_t          host_addr;   // next read address
    ibuf_pkg::qw_cnt_t             qw_left;
    ibuf_pkg::ring_ptr_t           iprod;       // reserved producer
    ibuf_pkg::rq_qw_t              max_qw;
    ibuf_pkg::rq_qw_t              rq_qw;
    logic [ibuf_pkg::OS_PTR_W:0]   os_cnt;
    ibuf_pkg::ring_ptr_t           used;
    logic [ibuf_pkg::RING_AW+1:0]  need;
    logic                          space_ok;
    logic                          os_ok;
    logic                          taken;

    assign taken      = (state == S_REQ) && rd_ack;
    assign used       = iprod - committed_cons;
    assign need       = {1'b0, used} + {3'b000, rq_qw};
    assign space_ok   = need <= ibuf_pkg::RING_QWS;
    assign os_ok      = os_cnt < (ibuf_pkg::OS_PTR_W + 1)'(ibuf_pkg::MAX_OUTSTANDING);
    assign lbuf_ready = state == S_IDLE;
    assign rd         = '{addr: host_addr, qw: rq_qw};

    always_ff @(posedge clk) begin
        case (cfg_max_rd)
            3'd0:    max_qw <= 8'd16;  // 128 B
            3'd1:    max_qw <= 8'd32;
            3'd2:    max_qw <= 8'd64;
            default: max_qw <= 8'd128; // 1 KB and above clipped
        endcase
    end

    //////////////////////////////////////////////////
    // request fsm
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= S_IDLE;
            rd_valid    <= 1'b0;
            issue_valid <= 1'b0;
            lbuf_done   <= 1'b0;
            iprod       <= '0;
        end else begin
            issue_valid <= 1'b0;
            lbuf_done   <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (lbuf_valid) begin
                        host_addr <= lbuf.addr;
                        qw_left   <= lbuf.len;
                        state     <= S_SIZE;
                    end
                end
                S_SIZE: begin
                    rq_qw <= (qw_left > {12'd0, max_qw}) ? max_qw : qw_left[7:0];
                    state <= S_WAIT;
                end
                S_WAIT: begin
                    if (os_ok && space_ok) begin
                        rd_valid <= 1'b1;
                        state    <= S_REQ;
                    end
                end
                S_REQ: begin
                    if (rd_ack) begin                   // tag comes with the ack
                        rd_valid    <= 1'b0;
                        issue_valid <= 1'b1;
                        issue       <= '{tag: rd_tag, qw: rq_qw, base: iprod};
                        iprod       <= iprod + {2'b00, rq_qw};
                        host_addr   <= host_addr + {53'd0, rq_qw, 3'd0};
                        qw_left     <= qw_left - {12'd0, rq_qw};
                        state       <= S_NEXT;
                    end
                end
                S_NEXT: begin
                    state <= (qw_left != '0) ? S_SIZE : S_DONE;
                end
                S_DONE: begin
                    lbuf_done <= 1'b1;
                    state     <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // in flight count, up on issue, down on retire
    always_ff @(posedge clk) begin
        if (rst) begin
            os_cnt <= '0;
        end else if (taken && !retire_valid) begin
            os_cnt <= os_cnt + 1'b1;
        end else if (retire_valid && !taken) begin
            os_cnt <= os_cnt - 1'b1;
        end
    end

    a_os_limit: assert property (@(posedge clk) disable iff (rst)
        os_cnt <= (ibuf_pkg::OS_PTR_W + 1)'(ibuf_pkg::MAX_OUTSTANDING));

endmodule

/* ibuf_mgmt/cpl_filter.sv */
/*
 * Completion filter: expected tag map, header check,
 * start notice to the ring writer
 */

module cpl_filter (
    input  logic                 clk,
    input  logic                 rst,
    input  pcie_pkg::rx_beat_t   rx,
    input  ibuf_pkg::issue_evt_t issue,
    input  logic                 issue_valid,
    input  logic                 retire_valid,
    input  pcie_pkg::tag_t       retire_tag,
    output ibuf_pkg::cpl_start_t cpl_start,
    output logic                 cpl_start_valid
);

    typedef enum logic {S_SOF, S_TAG} state_t;

    state_t                        state;
    logic [pcie_pkg::NUM_TAGS-1:0] expected;
    pcie_pkg::dw_len_t             len_q;
    pcie_pkg::tag_t                hdr_tag;
    logic                          hdr_ok;

    // successful cpld on the first header beat
    assign hdr_ok = rx.valid && rx.sof
        && (rx.data[pcie_pkg::FMT_TYPE_LSB +: 7] == pcie_pkg::FMT_TYPE_CPLD)
        && (rx.data[pcie_pkg::CPL_STATUS_LSB +: 3] == pcie_pkg::CPL_STATUS_SC);
    assign hdr_tag = rx.data[pcie_pkg::CPL_TAG_LSB +: 5];

    always_ff @(posedge clk) begin
        if (rst) begin
            expected <= '0;
        end else begin
            if (retire_valid) expected[retire_tag] <= 1'b0;
            if (issue_valid)  expected[issue.tag]  <= 1'b1;  // set wins on reuse
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state           <= S_SOF;
            cpl_start_valid <= 1'b0;
        end else begin
            cpl_start_valid <= 1'b0;
            case (state)
                S_SOF: begin
                    if (hdr_ok) begin
                        len_q <= rx.data[pcie_pkg::CPL_LEN_LSB +: 10];
                        state <= S_TAG;
                    end
                end
                S_TAG: begin
                    if (rx.valid) begin
                        if (expected[hdr_tag]) begin
                            cpl_start_valid <= 1'b1;
                            cpl_start       <= '{tag: hdr_tag, len: len_q};
                        end
                        state <= S_SOF;
                    end
                end
            endcase
        end
    end

    a_tag_unique: assert property (@(posedge clk) disable iff (rst)
        issue_valid && !(retire_valid && retire_tag == issue.tag) |-> !expected[issue.tag]);

endmodule

/* ibuf_mgmt/cpl_writer.sv */
/*
 * Ring writer: per-tag ring pointer and received count tables,
 * payload write port, request done detection
 */

module cpl_writer (
    input  logic                 clk,
    input  logic                 rst,
    input  pcie_pkg::rx_beat_t   rx,
    input  ibuf_pkg::cpl_start_t cpl_start,
    input  logic                 cpl_start_valid,
    input  ibuf_pkg::issue_evt_t issue,
    input  logic                 issue_valid,
    output ibuf_pkg::ring_wr_t   ring_wr,
    output logic                 req_done_valid,
    output pcie_pkg::tag_t       req_done_tag
);

    typedef enum logic {S_IDLE, S_DATA} state_t;

    state_t               state;
    ibuf_pkg::ring_ptr_t  ptr_tbl [pcie_pkg::NUM_TAGS];  // next free slot
    ibuf_pkg::rq_qw_t     rcv_tbl [pcie_pkg::NUM_TAGS];
    ibuf_pkg::rq_qw_t     len_tbl [pcie_pkg::NUM_TAGS];

    pcie_pkg::tag_t       tag_q;
    pcie_pkg::tag_t       cur_tag;
    ibuf_pkg::ring_ptr_t  ptr_q;
    ibuf_pkg::ring_ptr_t  cur_ptr;
    ibuf_pkg::ring_ptr_t  ptr_nxt;
    ibuf_pkg::rq_qw_t     cnt_q;
    ibuf_pkg::rq_qw_t     cur_cnt;
    ibuf_pkg::rq_qw_t     cnt_nxt;
    logic                 active;
    logic                 wr_beat;
    logic                 last_beat;
    logic                 done_q;
    logic                 wr_en;
    ibuf_pkg::ring_addr_t wr_addr;
    logic [63:0]          wr_data;
    logic [9:0]           cpl_end;

    // first payload beat lines up with the start notice
    assign active    = cpl_start_valid || (state == S_DATA);
    assign cur_tag   = cpl_start_valid ? cpl_start.tag          : tag_q;
    assign cur_ptr   = cpl_start_valid ? ptr_tbl[cpl_start.tag] : ptr_q;
    assign cur_cnt   = cpl_start_valid ? rcv_tbl[cpl_start.tag] : cnt_q;
    assign ptr_nxt   = cur_ptr + 1'b1;
    assign cnt_nxt   = cur_cnt + 1'b1;
    assign wr_beat   = active && rx.valid;
    assign last_beat = wr_beat && rx.eof;
    assign ring_wr   = '{en: wr_en, addr: wr_addr, data: wr_data};

    //////////////////////////////////////////////////
    // per-tag tables
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (issue_valid) begin
            ptr_tbl[issue.tag] <= issue.base;
            rcv_tbl[issue.tag] <= '0;
            len_tbl[issue.tag] <= issue.qw;
        end
        if (last_beat) begin        // save progress for the next cpl of this tag
            ptr_tbl[cur_tag] <= ptr_nxt;
            rcv_tbl[cur_tag] <= cnt_nxt;
        end
    end

    always_ff @(posedge clk) begin
        wr_addr      <= cur_ptr[ibuf_pkg::RING_AW-1:0];
        wr_data      <= rx.data;
        req_done_tag <= tag_q;
        if (active) begin
            tag_q <= cur_tag;
            ptr_q <= wr_beat ? ptr_nxt : cur_ptr;
            cnt_q <= wr_beat ? cnt_nxt : cur_cnt;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= S_IDLE;
            wr_en          <= 1'b0;
            done_q         <= 1'b0;
            req_done_valid <= 1'b0;
        end else begin
            wr_en          <= wr_beat;
            done_q         <= last_beat && (cnt_nxt == len_tbl[cur_tag]);
            req_done_valid <= done_q;   // one cycle behind the eof write
            if (last_beat) begin
                state <= S_IDLE;
            end else if (cpl_start_valid) begin
                state <= S_DATA;
            end
        end
    end

    // qws already in plus this completion's payload
    assign cpl_end = {2'b00, rcv_tbl[cpl_start.tag]} + {1'b0, cpl_start.len[9:1]};

    a_no_overrun: assert property (@(posedge clk) disable iff (rst)
        cpl_start_valid |-> cpl_end <= {2'b00, len_tbl[cpl_start.tag]});

endmodule

/* ibuf_mgmt/commit_ctrl.sv */
/*
 * Commit control: in-order queue of issued requests,
 * done map, committed producer update and tag retire
 */

module commit_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    input  ibuf_pkg::issue_evt_t issue,
    input  logic                 issue_valid,
    input  logic                 req_done_valid,
    input  pcie_pkg::tag_t       req_done_tag,
    output ibuf_pkg::ring_ptr_t  committed_prod,
    output logic                 retire_valid,
    output pcie_pkg::tag_t       retire_tag
);

    pcie_pkg::tag_t                q_tag [ibuf_pkg::MAX_OUTSTANDING];
    ibuf_pkg::ring_ptr_t           q_end [ibuf_pkg::MAX_OUTSTANDING];
    logic [ibuf_pkg::OS_PTR_W:0]   wr_ptr;
    logic [ibuf_pkg::OS_PTR_W:0]   rd_ptr;
    logic [pcie_pkg::NUM_TAGS-1:0] done_map;
    pcie_pkg::tag_t                head_tag;
    logic                          empty;
    logic                          head_done;

    assign empty     = wr_ptr == rd_ptr;
    assign head_tag  = q_tag[rd_ptr[ibuf_pkg::OS_PTR_W-1:0]];
    // done notice for the head commits without a stop in the map
    assign head_done = !empty && (done_map[head_tag]
                       || (req_done_valid && (req_done_tag == head_tag)));

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            q_tag[wr_ptr[ibuf_pkg::OS_PTR_W-1:0]] <= issue.tag;
            q_end[wr_ptr[ibuf_pkg::OS_PTR_W-1:0]] <= issue.base + {2'b00, issue.qw};
        end
        if (head_done) retire_tag <= head_tag;
    end

    //////////////////////////////////////////////////
    // pointer update, strictly in issue order
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr         <= '0;
            rd_ptr         <= '0;
            done_map       <= '0;
            committed_prod <= '0;
            retire_valid   <= 1'b0;
        end else begin
            retire_valid <= head_done;
            if (issue_valid) wr_ptr <= wr_ptr + 1'b1;
            if (req_done_valid) done_map[req_done_tag] <= 1'b1;
            if (head_done) begin
                done_map[head_tag] <= 1'b0;
                committed_prod     <= q_end[rd_ptr[ibuf_pkg::OS_PTR_W-1:0]];
                rd_ptr             <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

/* ibuf_mgmt/ibuf_mgmt.sv */
/*
 * Inbound buffer manager top: read generation, completion
 * filter, ring writer and commit control
 */

module ibuf_mgmt (
    input  logic                   clk,
    input  logic                   rst,
    input  ibuf_pkg::lbuf_desc_t   lbuf,
    input  logic                   lbuf_valid,
    output logic                   lbuf_ready,
    output pcie_pkg::rd_req_t      rd,
    output logic                   rd_valid,
    input  logic                   rd_ack,
    input  pcie_pkg::tag_t         rd_tag,
    input  pcie_pkg::rx_beat_t     rx,
    output ibuf_pkg::ring_wr_t     ring_wr,
    output ibuf_pkg::ring_ptr_t    committed_prod,
    input  ibuf_pkg::ring_ptr_t    committed_cons,
    input  pcie_pkg::max_rd_code_t cfg_max_rd,
    output logic                   lbuf_done
);

    ibuf_pkg::issue_evt_t issue;
    logic                 issue_valid;
    ibuf_pkg::cpl_start_t cpl_start;
    logic                 cpl_start_valid;
    logic                 req_done_valid;
    pcie_pkg::tag_t       req_done_tag;
    logic                 retire_valid;
    pcie_pkg::tag_t       retire_tag;

    rd_req_gen rd_req_gen_inst (
        .clk            (clk),
        .rst            (rst),
        .lbuf           (lbuf),
        .lbuf_valid     (lbuf_valid),
        .lbuf_ready     (lbuf_ready),
        .cfg_max_rd     (cfg_max_rd),
        .rd             (rd),
        .rd_valid       (rd_valid),
        .rd_ack         (rd_ack),
        .rd_tag         (rd_tag),
        .committed_cons (committed_cons),
        .retire_valid   (retire_valid),
        .issue          (issue),
        .issue_valid    (issue_valid),
        .lbuf_done      (lbuf_done)
    );

    cpl_filter cpl_filter_inst (
        .clk             (clk),
        .rst             (rst),
        .rx              (rx),
        .issue           (issue),
        .issue_valid     (issue_valid),
        .retire_valid    (retire_valid),
        .retire_tag      (retire_tag),
        .cpl_start       (cpl_start),
        .cpl_start_valid (cpl_start_valid)
    );

    cpl_writer cpl_writer_inst (
        .clk             (clk),
        .rst             (rst),
        .rx              (rx),
        .cpl_start       (cpl_start),
        .cpl_start_valid (cpl_start_valid),
        .issue           (issue),
        .issue_valid     (issue_valid),
        .ring_wr         (ring_wr),
        .req_done_valid  (req_done_valid),
        .req_done_tag    (req_done_tag)
    );

    commit_ctrl commit_ctrl_inst (
        .clk            (clk),
        .rst            (rst),
        .issue          (issue),
        .issue_valid    (issue_valid),
        .req_done_valid (req_done_valid),
        .req_done_tag   (req_done_tag),
        .committed_prod (committed_prod),
        .retire_valid   (retire_valid),
        .retire_tag     (retire_tag)
    );

endmodule

/* tb/tb_ibuf_mgmt.sv */
/*
 * Testbench for the inbound buffer manager: host read and
 * completion model, ring model, consumer, checks and report
 */

module tb_ibuf_mgmt;

    typedef struct packed {
        logic [1:0]           kind;   // 0 good, 1 wrong type, 2 bad status, 3 stray tag
        pcie_pkg::tag_t       tag;
        pcie_pkg::host_addr_t addr;
        ibuf_pkg::rq_qw_t     qw;
    } cpl_job_t;

    typedef struct packed {
        pcie_pkg::tag_t      tag;
        ibuf_pkg::ring_ptr_t end_ptr;
    } req_rec_t;

    localparam int TMO = 20000;

    logic                   clk;
    logic                   rst;
    ibuf_pkg::lbuf_desc_t   lbuf;
    logic                   lbuf_valid;
    logic                   lbuf_ready;
    pcie_pkg::rd_req_t      rd;
    logic                   rd_valid;
    logic                   rd_ack;
    pcie_pkg::tag_t         rd_tag;
    pcie_pkg::rx_beat_t     rx;
    ibuf_pkg::ring_wr_t     ring_wr;
    ibuf_pkg::ring_ptr_t    committed_prod;
    ibuf_pkg::ring_ptr_t    committed_cons;
    pcie_pkg::max_rd_code_t cfg_max_rd;
    logic                   lbuf_done;

    logic [31:0]          seed;
    int                   errors;
    int                   checks;
    int                   test_num;
    int                   test_err;
    int                   done_cnt;
    int                   bufs_started;
    int                   wr_cnt;
    int                   prod_moves;
    int                   outstanding;
    logic                 cons_stall;
    logic                 junk_on;
    logic [15:0]          tag_busy;
    ibuf_pkg::ring_ptr_t  resv;         // model of reserved producer
    ibuf_pkg::ring_ptr_t  last_prod;
    pcie_pkg::host_addr_t buf_next;
    ibuf_pkg::qw_cnt_t    buf_left;
    logic [63:0]          exp_mem [512];
    logic [63:0]          ring_mem [512];
    cpl_job_t             cq [$];       // completions waiting to be sent
    cpl_job_t             cq_new [$];   // completions of reads just accepted
    req_rec_t             reqq [$];     // issued requests in order

    ibuf_mgmt ibuf_mgmt_inst (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function int rand_below(input int n);
        logic [31:0] r;
        r = lcg_next();
        return int'(r[30:8]) % n;
    endfunction

    // max read request size in qws, 128 B doubling per code, capped at 1 KB
    function int max_qw_for(input pcie_pkg::max_rd_code_t code);
        return (code >= 3'd3) ? 128 : (16 << code);
    endfunction

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("timeout while waiting for %s at time %0t", what, $time);
        $display("*** FAILED ***");
        $finish;
    endtask

    //////////////////////////////////////////////////
    // host side: read accept, monitors, consumer
    //////////////////////////////////////////////////
    always @(negedge clk) begin
        int n;
        int sz;
        int rem;
        int t;
        logic found;
        pcie_pkg::host_addr_t a;
        logic [10:0] need;
        rd_ack = 1'b0;
        if (!rst) begin
            if (ring_wr.en) begin
                ring_mem[ring_wr.addr] = ring_wr.data;
                wr_cnt++;
            end
            if (committed_prod != last_prod) begin
                if (reqq.size() == 0) begin
                    check(64'(committed_prod), 64'(last_prod), "commit with nothing issued");
                end else begin
                    check(64'(committed_prod), 64'(reqq[0].end_ptr), "commit pointer");
                    tag_busy[reqq[0].tag[3:0]] = 1'b0;
                    outstanding--;
                    void'(reqq.pop_front());
                end
                last_prod = committed_prod;
                prod_moves++;
            end
            if (lbuf_done) begin
                check(64'(done_cnt < bufs_started), 64'd1, "lbuf_done without a buffer");
                check(64'(buf_left), 64'd0, "buffer left at done");
                done_cnt++;
            end
            if (rd_valid && rand_below(3) == 0) begin
                check(64'(rd.qw <= max_qw_for(cfg_max_rd)), 64'd1, "read size limit");
                check(64'(rd.qw != 0 && rd.qw <= buf_left), 64'd1, "read length");
                check(rd.addr, buf_next, "read address");
                need = {1'b0, resv - committed_cons} + {3'b000, rd.qw};
                check(64'(need <= 11'd512), 64'd1, "ring space");
                check(64'(outstanding < ibuf_pkg::MAX_OUTSTANDING), 64'd1, "outstanding");
                buf_next = buf_next + {53'd0, rd.qw, 3'd0};
                buf_left = buf_left - {12'd0, rd.qw};
                n = rand_below(16);
                found = 1'b0;
                t = 0;
                for (int k = 0; k < 16; k++) begin
                    if (!found && !tag_busy[(n + k) % 16]) begin
                        t = (n + k) % 16;
                        found = 1'b1;
                    end
                end
                tag_busy[t] = 1'b1;
                rd_tag = 5'(t);
                rd_ack = 1'b1;
                for (int i = 0; i < int'(rd.qw); i++) begin
                    exp_mem[9'(resv + 10'(i))] = rd.addr + 64'(i * 8);
                end
                // one to three completions per read
                n = 1 + rand_below(3);
                if (n > int'(rd.qw)) n = int'(rd.qw);
                rem = int'(rd.qw);
                a = rd.addr;
                for (int k = 0; k < n; k++) begin
                    sz = (k == n - 1) ? rem : 1 + rand_below(rem - (n - 1 - k));
                    cq_new.push_back('{kind: 2'd0, tag: 5'(t), addr: a, qw: 8'(sz)});
                    a = a + 64'(sz * 8);
                    rem = rem - sz;
                end
                reqq.push_back('{tag: 5'(t), end_ptr: resv + {2'b00, rd.qw}});
                resv = resv + {2'b00, rd.qw};
                outstanding++;
            end
            // consumer walks the committed words
            if (!cons_stall && committed_cons != committed_prod && rand_below(2) == 0) begin
                check(ring_mem[committed_cons[8:0]], exp_mem[committed_cons[8:0]], "ring word");
                committed_cons = committed_cons + 1'b1;
            end
        end
    end

    // completions of a read become sendable once the read is taken
    always @(posedge clk) begin
        foreach (cq_new[k]) cq.push_back(cq_new[k]);
        cq_new.delete();
    end

    task automatic send_tlp(input cpl_job_t j);
        logic [63:0] h0;
        logic [63:0] h1;
        h0 = '0;
        h0[62:56] = (j.kind == 2'd1) ? 7'b000_1010 : pcie_pkg::FMT_TYPE_CPLD;
        h0[41:32] = {1'b0, j.qw, 1'b0};           // dw count
        h0[15:13] = (j.kind == 2'd2) ? 3'b001 : pcie_pkg::CPL_STATUS_SC;
        h1 = '0;
        h1[44:40] = j.tag;
        rx = '{data: h0, sof: 1'b1, eof: 1'b0, valid: 1'b1};
        @(negedge clk);
        rx = '{data: h1, sof: 1'b0, eof: 1'b0, valid: 1'b1};
        @(negedge clk);
        for (int i = 0; i < int'(j.qw); i++) begin
            rx = '{data: j.addr + 64'(i * 8), sof: 1'b0, eof: (i == int'(j.qw) - 1),
                   valid: 1'b1};
            @(negedge clk);
        end
        rx = '0;
    endtask

    function cpl_job_t make_junk();
        cpl_job_t j;
        j.kind = 2'(1 + rand_below(3));
        j.tag  = (j.kind == 2'd3) ? 5'(16 + rand_below(16)) : 5'(rand_below(32));
        j.addr = 64'hdead_0000;
        j.qw   = 8'(1 + rand_below(4));
        return j;
    endfunction

    // completion sender, interleaves tags but keeps each tag in order
    initial begin
        int j;
        int i;
        rx = '0;
        forever begin
            @(negedge clk);
            if (!rst && junk_on && rand_below(8) == 0) begin
                send_tlp(make_junk());
            end else if (!rst && cq.size() > 0 && rand_below(2) == 0) begin
                j = rand_below(cq.size());
                i = 0;
                while (cq[i].tag != cq[j].tag) i++;
                send_tlp(cq[i]);
                cq.delete(i);
            end
        end
    end

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////
    task automatic wait_cycles_until_idle();
        int cnt;
        cnt = 0;
        while (!(done_cnt == bufs_started && lbuf_ready)) begin
            @(negedge clk);
            cnt++;
            if (cnt > TMO) timeout_fail("buffer done");
        end
    endtask

    task automatic run_buffer(input pcie_pkg::host_addr_t addr, input int len,
                              input pcie_pkg::max_rd_code_t code);
        wait_cycles_until_idle();
        cfg_max_rd = code;
        buf_next   = addr;
        buf_left   = 20'(len);
        lbuf       = '{addr: addr, len: 20'(len)};
        lbuf_valid = 1'b1;
        @(negedge clk);
        lbuf_valid = 1'b0;
        bufs_started++;
    endtask

    task automatic drain();
        int cnt;
        wait_cycles_until_idle();
        cnt = 0;
        while (reqq.size() != 0 || cq.size() != 0 || committed_cons != committed_prod) begin
            @(negedge clk);
            cnt++;
            if (cnt > TMO) timeout_fail("ring drain");
        end
    endtask

    task automatic end_test(input string name);
        test_num++;
        $display("test %0d %s: %s (%0d errors)", test_num, name,
                 (errors == test_err) ? "ok" : "bad", errors - test_err);
        test_err = errors;
    endtask

    initial begin
        int w0;
        ibuf_pkg::ring_ptr_t p0;
        seed = 32'hcde6;
        {errors, checks, test_num, test_err, done_cnt, bufs_started} = '0;
        {wr_cnt, prod_moves, outstanding} = '0;
        rst = 1'b1;
        lbuf = '0;
        lbuf_valid = 1'b0;
        rd_ack = 1'b0;
        rd_tag = '0;
        committed_cons = '0;
        cfg_max_rd = '0;
        cons_stall = 1'b0;
        junk_on = 1'b0;
        tag_busy = '0;
        resv = '0;
        last_prod = '0;
        buf_next = '0;
        buf_left = '0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check(64'(rd_valid), 64'd0, "rd_valid after reset");
        check(64'(lbuf_done), 64'd0, "lbuf_done after reset");
        check(64'(ring_wr.en), 64'd0, "ring write after reset");
        check(64'(lbuf_ready), 64'd1, "lbuf_ready after reset");
        check(64'(committed_prod), 64'd0, "committed_prod after reset");
        end_test("reset");

        junk_on = 1'b1;
        for (int b = 0; b < 12; b++) begin
            run_buffer({32'h0, lcg_next()} << 3, 1 + rand_below(400), 3'(rand_below(8)));
        end
        drain();
        check(64'(done_cnt), 64'(bufs_started), "lbuf_done count");
        end_test("random buffers");

        // junk alone on an idle ring
        junk_on = 1'b0;
        w0 = wr_cnt;
        p0 = committed_prod;
        for (int k = 0; k < 6; k++) cq.push_back(make_junk());
        drain();
        repeat (4) @(negedge clk);
        check(64'(wr_cnt), 64'(w0), "ring writes from junk");
        check(64'(committed_prod), 64'(p0), "committed_prod after junk");
        end_test("junk tlps");

        cons_stall = 1'b1;
        run_buffer(64'h0000_0001_0000_0000, 700, 3'd3);
        repeat (600) @(negedge clk);
        cons_stall = 1'b0;
        drain();
        check(64'(done_cnt), 64'(bufs_started), "lbuf_done count");
        end_test("consumer stall");

        $display("tests %0d, checks %0d, errors %0d, buffers %0d, commits %0d",
                 test_num, checks, errors, done_cnt, prod_moves);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* project.f */
common/pcie_pkg.sv
common/ibuf_pkg.sv
ibuf_mgmt/rd_req_gen.sv
ibuf_mgmt/cpl_filter.sv
ibuf_mgmt/cpl_writer.sv
ibuf_mgmt/commit_ctrl.sv
ibuf_mgmt/ibuf_mgmt.sv
tb/tb_ibuf_mgmt.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_ibuf_mgmt
RTL_TOP   = ibuf_mgmt
FLIST     = project.f
OBJ       = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ)
	./$(OBJ)/V$(TOP) | tee $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@grep -q 'PASSED' $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)
